//--- flist.f
+incdir+src
src/audio_reg_pkg.sv
src/audio_data_pkg.sv
src/sample_channel.sv
src/sample_mem_arbiter.sv
src/sample_mem.sv
src/channel_mixer.sv
src/i2s_serializer.sv
src/audio_top.sv
verif/audio_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module audio_tb \
    -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vaudio_tb > sim.log 2>&1

grep -q "Test OK" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- src/audio_data_pkg.sv
`include "audio_params.svh"

package audio_data_pkg;

    typedef logic [`AUDIO_ADDR_W-1:0] sample_addr_t;

    typedef struct packed {
        logic         en;
        sample_addr_t addr;
        logic [15:0]  data;
    } mem_write_t;

    typedef struct packed {
        logic signed [15:0] sample;
        logic [7:0]         volume;
        logic               left_en;
        logic               right_en;
    } chan_sample_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

endpackage

//--- src/audio_params.svh
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Playback channel count
`define AUDIO_NUM_CHANNELS 4

// Sample memory size in 16-bit words
`define AUDIO_MEM_DEPTH 4096

// Sample address width matching the memory depth
`define AUDIO_ADDR_W 12

// clk cycles per bclk half period
`define AUDIO_BCLK_DIV 2

`endif

//--- src/audio_reg_pkg.sv
`include "audio_params.svh"

package audio_reg_pkg;

    localparam logic [3:0] REG_START   = 4'd2;
    localparam logic [3:0] REG_END     = 4'd4;
    localparam logic [3:0] REG_CTRL    = 4'd8;
    localparam logic [3:0] REG_TRIGGER = 4'd9;

    typedef struct packed {
        logic [11:0] rsvd;
        logic [7:0]  volume;
        logic        loop;
        logic        right_en;
        logic        left_en;
        logic        enable;
    } chan_ctrl_t;

    typedef struct packed {
        logic [23-`AUDIO_ADDR_W:0] rsvd;
        logic [`AUDIO_ADDR_W-1:0]  addr;
    } reg_addr_t;

    // START and END use the address view, CTRL the control view
    typedef union packed {
        reg_addr_t  as_addr;
        chan_ctrl_t as_ctrl;
    } reg_word_u;

    typedef struct packed {
        logic       strobe;
        logic [7:0] chan;
        logic [3:0] sel;
        reg_word_u  data;
    } reg_write_t;

endpackage

//--- src/audio_top.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_top
    import audio_reg_pkg::*;
    import audio_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  reg_write_t reg_wr,
    input  mem_write_t mem_wr,
    output logic       audio_bclk,
    output logic       audio_lrclk,
    output logic       audio_dout
);

    localparam int N = `AUDIO_NUM_CHANNELS;

    logic [N-1:0] rd_req;
    logic [N-1:0] rd_grant;
    sample_addr_t rd_addr [N];
    chan_sample_t chan_samples [N];
    logic         mem_rd_en;
    sample_addr_t mem_rd_addr;
    logic [15:0]  mem_rd_data;
    stereo_t      mix_frame;
    logic         frame_start;

    for (genvar i = 0; i < N; i++) begin : g_chan
        sample_channel #(
            .CHAN_ID(i)
        ) u_chan (
            .clk        (clk),
            .rst        (rst),
            .reg_wr     (reg_wr),
            .frame_start(frame_start),
            .rd_req     (rd_req[i]),
            .rd_addr    (rd_addr[i]),
            .rd_grant   (rd_grant[i]),
            .rd_data    (mem_rd_data),
            .chan_out   (chan_samples[i])
        );
    end

    sample_mem_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (rd_req),
        .rd_addr_in (rd_addr),
        .rd_grant   (rd_grant),
        .mem_rd_en  (mem_rd_en),
        .mem_rd_addr(mem_rd_addr)
    );

    sample_mem u_mem (
        .clk    (clk),
        .wr     (mem_wr),
        .rd_en  (mem_rd_en),
        .rd_addr(mem_rd_addr),
        .rd_data(mem_rd_data)
    );

    channel_mixer u_mix (
        .clk    (clk),
        .rst    (rst),
        .chan_in(chan_samples),
        .mix_out(mix_frame)
    );

    i2s_serializer u_i2s (
        .clk        (clk),
        .rst        (rst),
        .frame_in   (mix_frame),
        .frame_start(frame_start),
        .bclk       (audio_bclk),
        .lrclk      (audio_lrclk),
        .dout       (audio_dout)
    );

endmodule

//--- src/channel_mixer.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module channel_mixer
    import audio_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  chan_sample_t chan_in [`AUDIO_NUM_CHANNELS],
    output stereo_t      mix_out
);

    localparam int N     = `AUDIO_NUM_CHANNELS;
    localparam int SUM_W = 18 + ((N > 1) ? $clog2(N) : 1);

    logic signed [9:0]       gain   [N];
    logic signed [25:0]      prod   [N];
    logic signed [17:0]      scaled [N];
    logic signed [SUM_W-1:0] sum_l;
    logic signed [SUM_W-1:0] sum_r;

    function automatic logic signed [15:0] sat16(input logic signed [SUM_W-1:0] v);
        if (v[SUM_W-1:15] == {(SUM_W-15){v[SUM_W-1]}}) begin
            return v[15:0];
        end else if (v[SUM_W-1]) begin
            return 16'sh8000;
        end else begin
            return 16'sh7fff;
        end
    endfunction

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < N; i++) begin
            gain[i]   = {2'b00, chan_in[i].volume} + 10'd1;
            prod[i]   = 26'(chan_in[i].sample) * 26'(gain[i]);
            scaled[i] = prod[i][25:8]; // Arithmetic shift by 8
            if (chan_in[i].left_en) begin
                sum_l = sum_l + SUM_W'(scaled[i]);
            end
            if (chan_in[i].right_en) begin
                sum_r = sum_r + SUM_W'(scaled[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mix_out <= '0;
        end else begin
            mix_out.left  <= sat16(sum_l);
            mix_out.right <= sat16(sum_r);
        end
    end

endmodule

//--- src/i2s_serializer.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module i2s_serializer
    import audio_data_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  stereo_t frame_in,
    output logic    frame_start,
    output logic    bclk,
    output logic    lrclk,
    output logic    dout
);

    localparam int DIV = `AUDIO_BCLK_DIV;
    localparam int DW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [DW-1:0] div_cnt;
    logic [4:0]    bit_cnt;
    logic [4:0]    bit_nxt;
    logic [31:0]   shift;
    logic          half_done;
    logic          bclk_fall;

    assign half_done = (div_cnt == DW'(DIV - 1));
    assign bclk_fall = half_done && bclk;
    assign bit_nxt   = bit_cnt + 5'd1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end else if (half_done) begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Count 32 bclk periods per stereo frame
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt     <= 5'd31; // First falling edge opens a frame
            lrclk       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= bclk_fall && (bit_cnt == 5'd31);
            if (bclk_fall) begin
                bit_cnt <= bit_nxt;
                lrclk   <= bit_nxt[4]; // High for the right half
            end
        end
    end

    // dout lags lrclk by one bclk, so it takes the old MSB
    always_ff @(posedge clk) begin
        if (!rst) begin
            shift <= '0;
            dout  <= 1'b0;
        end else if (bclk_fall) begin
            dout <= shift[31];
            if (bit_cnt == 5'd31) begin
                shift <= {frame_in.left, frame_in.right};
            end else begin
                shift <= {shift[30:0], 1'b0};
            end
        end
    end

endmodule

//--- src/sample_channel.sv
`timescale 1ns/1ps

module sample_channel
    import audio_reg_pkg::*;
    import audio_data_pkg::*;
#(
    parameter int CHAN_ID = 0
) (
    input  logic         clk,
    input  logic         rst,
    input  reg_write_t   reg_wr,
    input  logic         frame_start,
    output logic         rd_req,
    output sample_addr_t rd_addr,
    input  logic         rd_grant,
    input  logic [15:0]  rd_data,
    output chan_sample_t chan_out
);

    sample_addr_t       start_addr;
    sample_addr_t       end_addr;
    sample_addr_t       ptr;
    chan_ctrl_t         ctrl;
    logic               playing;
    logic               data_pending;
    logic signed [15:0] sample;
    logic               wr_hit;

    assign wr_hit = reg_wr.strobe && (reg_wr.chan == 8'(CHAN_ID));

    always_ff @(posedge clk) begin
        if (!rst) begin
            start_addr   <= '0;
            end_addr     <= '0;
            ptr          <= '0;
            ctrl         <= '0;
            playing      <= 1'b0;
            rd_req       <= 1'b0;
            data_pending <= 1'b0;
            sample       <= '0;
        end else begin
            data_pending <= rd_grant; // RAM data lands next cycle

            if (rd_grant) begin
                rd_req <= 1'b0;
            end else if (frame_start && ctrl.enable && playing) begin
                rd_req <= 1'b1;
            end

            if (frame_start && !(ctrl.enable && playing)) begin
                sample <= '0; // Silent after one-shot end
            end

            if (data_pending && ctrl.enable) begin
                sample <= rd_data;
                if (ptr == end_addr) begin
                    if (ctrl.loop) begin
                        ptr <= start_addr;
                    end else begin
                        playing <= 1'b0;
                    end
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end

            // Host writes take priority over the fetch update
            if (wr_hit) begin
                case (reg_wr.sel)
                    REG_START: start_addr <= reg_wr.data.as_addr.addr;
                    REG_END:   end_addr   <= reg_wr.data.as_addr.addr;
                    REG_CTRL: begin
                        ctrl <= reg_wr.data.as_ctrl;
                        if (!reg_wr.data.as_ctrl.enable) begin
                            sample <= '0;
                        end
                    end
                    REG_TRIGGER: begin
                        playing <= 1'b1;
                        ptr     <= start_addr;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign rd_addr = ptr;

    assign chan_out.sample   = sample;
    assign chan_out.volume   = ctrl.volume;
    assign chan_out.left_en  = ctrl.left_en;
    assign chan_out.right_en = ctrl.right_en;

endmodule

//--- src/sample_mem.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module sample_mem
    import audio_data_pkg::*;
(
    input  logic         clk,
    input  mem_write_t   wr,
    input  logic         rd_en,
    input  sample_addr_t rd_addr,
    output logic [15:0]  rd_data
);

    logic [15:0] mem [`AUDIO_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // One-cycle registered read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- src/sample_mem_arbiter.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module sample_mem_arbiter
    import audio_data_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`AUDIO_NUM_CHANNELS-1:0] rd_req,
    input  sample_addr_t                   rd_addr_in [`AUDIO_NUM_CHANNELS],
    output logic [`AUDIO_NUM_CHANNELS-1:0] rd_grant,
    output logic                           mem_rd_en,
    output sample_addr_t                   mem_rd_addr
);

    localparam int N  = `AUDIO_NUM_CHANNELS;
    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic [CW-1:0] last;
    logic [CW-1:0] sel;
    logic          found;

    // Search starts one past the last winner
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        sel   = last;
        for (int i = 1; i <= N; i++) begin
            idx = (int'(last) + i) % N;
            if (!found && rd_req[idx]) begin
                found = 1'b1;
                sel   = idx[CW-1:0];
            end
        end
    end

    always_comb begin
        rd_grant = '0;
        if (found) begin
            rd_grant[sel] = 1'b1;
        end
    end

    assign mem_rd_en   = found;
    assign mem_rd_addr = rd_addr_in[sel];

    always_ff @(posedge clk) begin
        if (!rst) begin
            last <= CW'(N - 1); // Channel 0 wins first
        end else if (found) begin
            last <= sel;
        end
    end

endmodule

//--- verif/audio_tb.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_tb
    import audio_reg_pkg::*;
    import audio_data_pkg::*;
;

    logic       clk;
    logic       rst;
    reg_write_t reg_wr;
    mem_write_t mem_wr;
    logic       audio_bclk;
    logic       audio_lrclk;
    logic       audio_dout;

    int          seed = 27308;
    int          data_errors = 0;
    int          frame_errors = 0;
    int          frame_cnt = 0;
    logic [15:0] left_q[$];
    logic [15:0] right_q[$];
    logic [15:0] exp_q[$];
    logic [15:0] dec_sh;
    logic [15:0] cur_left;
    logic        dec_lr;

    logic bclk_d;
    logic lr_d;
    logic bclk_armed;
    logic lr_armed;
    int   half_cnt;
    int   lr_cnt;
    logic hung = 1'b0;

    audio_top DUT (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .mem_wr     (mem_wr),
        .audio_bclk (audio_bclk),
        .audio_lrclk(audio_lrclk),
        .audio_dout (audio_dout)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // I2S receiver ends a word where lrclk changes
    always @(posedge audio_bclk) begin
        logic [15:0] sh;
        if (rst) begin
            sh = {dec_sh[14:0], audio_dout};
            if (audio_lrclk != dec_lr) begin
                if (dec_lr) begin
                    left_q.push_back(cur_left);
                    right_q.push_back(sh);
                    frame_cnt++;
                end else begin
                    cur_left = sh;
                end
            end
            dec_sh = sh;
            dec_lr = audio_lrclk;
        end
    end

    // Framing monitors
    always @(posedge clk) begin
        if (!rst) begin
            bclk_d <= 1'b0;
            lr_d <= 1'b0;
            bclk_armed <= 1'b0;
            lr_armed <= 1'b0;
            half_cnt <= 0;
            lr_cnt <= 0;
        end else begin
            bclk_d <= audio_bclk;
            lr_d <= audio_lrclk;
            if (audio_bclk != bclk_d) begin
                half_cnt <= 1;
                bclk_armed <= 1'b1;
            end else begin
                half_cnt <= half_cnt + 1;
            end
            if (audio_lrclk != lr_d) begin
                lr_cnt <= 0;
                lr_armed <= 1'b1;
            end else if (audio_bclk && !bclk_d) begin
                lr_cnt <= lr_cnt + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        (bclk_armed && audio_bclk != bclk_d) |-> half_cnt == `AUDIO_BCLK_DIV)
    else begin
        $display("FAIL audio_bclk half period: got 0x%h expected 0x%h",
                 half_cnt, `AUDIO_BCLK_DIV);
        frame_errors++;
    end

    assert property (@(posedge clk) disable iff (!rst)
        (lr_armed && audio_lrclk != lr_d) |-> lr_cnt == 16)
    else begin
        $display("FAIL audio_lrclk bclk periods: got 0x%h expected 0x%h", lr_cnt, 16);
        frame_errors++;
    end

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        hung = 1'b1;
        forever @(negedge clk);
    endtask

    initial begin
        wait (hung);
        $display("Test FAILED");
        $finish;
    end

    task automatic wait_frames(input int n);
        int target;
        int t;
        target = frame_cnt + n;
        for (t = 0; t < n * 200 && frame_cnt < target; t++) @(negedge clk);
        if (frame_cnt < target) abort_run("decoded frames");
    endtask

    task automatic wait_lr(input logic lvl);
        int t;
        for (t = 0; t < 400 && audio_lrclk != lvl; t++) @(negedge clk);
        if (audio_lrclk != lvl) abort_run("lrclk level");
    endtask

    // Start of a right half leaves plenty of cycles before the next frame
    task automatic sync_right_half();
        wait_lr(1'b0);
        wait_lr(1'b1);
    endtask

    task automatic reg_write(input int ch, input logic [3:0] sel, input logic [23:0] data);
        reg_wr = {1'b1, 8'(ch), sel, data};
        @(negedge clk);
        reg_wr = '0;
    endtask

    task automatic mem_write(input int addr, input logic [15:0] data);
        mem_wr = {1'b1, sample_addr_t'(addr), data};
        @(negedge clk);
        mem_wr = '0;
    endtask

    function automatic logic [23:0] ctrl_word(input logic [7:0] vol, input logic loop,
                                              input logic r, input logic l, input logic en);
        return {12'h000, vol, loop, r, l, en};
    endfunction

    task automatic program_chan(input int ch, input int first, input int last,
                                input logic [23:0] ctrl);
        reg_write(ch, REG_START, 24'(first));
        reg_write(ch, REG_END, 24'(last));
        reg_write(ch, REG_CTRL, ctrl);
    endtask

    task automatic clear_capture();
        left_q = {};
        right_q = {};
    endtask

    // Nonzero words of one side against exp_q
    task automatic check_words(input bit right_side, input bit exact);
        logic [15:0] got[$];
        string       name;
        int          i;
        name = right_side ? "audio_dout right" : "audio_dout left";
        got = {};
        for (i = 0; i < left_q.size(); i++) begin
            if (right_side && right_q[i] != 0) got.push_back(right_q[i]);
            if (!right_side && left_q[i] != 0) got.push_back(left_q[i]);
        end
        assert (got.size() >= exp_q.size() && (!exact || got.size() == exp_q.size()))
        else begin
            $display("%s has %0d nonzero words where %0d were expected",
                     name, got.size(), exp_q.size());
            data_errors++;
        end
        for (i = 0; i < exp_q.size() && i < got.size(); i++) begin
            assert (got[i] == exp_q[i])
            else begin
                $display("FAIL %s word %0d: got 0x%h expected 0x%h", name, i, got[i], exp_q[i]);
                data_errors++;
            end
        end
    endtask

    task automatic check_tail_zero();
        assert (left_q.size() > 0 && left_q[$] == 0 && right_q[$] == 0)
        else begin
            $display("Output did not return to silence after the end address");
            data_errors++;
        end
    endtask

    logic [15:0] w [5];
    logic [15:0] v [5];
    int          s;
    int          i;

    initial begin
        rst = 1'b0;
        reg_wr = '0;
        mem_wr = '0;
        dec_sh = '0;
        cur_left = '0;
        dec_lr = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b1;

        // One-shot, full volume, left only
        exp_q = {};
        for (i = 0; i < 6; i++) begin
            w[0] = 16'($random(seed)) | 16'h0001;
            mem_write(16'h010 + i, w[0]);
            exp_q.push_back(w[0]);
        end
        program_chan(0, 16'h010, 16'h015, ctrl_word(8'd255, 1'b0, 1'b0, 1'b1, 1'b1));
        sync_right_half();
        clear_capture();
        reg_write(0, REG_TRIGGER, 24'h0);
        wait_frames(11);
        check_words(1'b0, 1'b1);
        exp_q = {};
        check_words(1'b1, 1'b1);
        check_tail_zero();

        // Volume 63 scales by 64/256
        exp_q = {};
        for (i = 0; i < 4; i++) begin
            w[0] = 16'($random(seed)) | 16'h0100;
            mem_write(16'h200 + i, w[0]);
            s = int'($signed(w[0]));
            s = (s * 64) >>> 8;
            exp_q.push_back(s[15:0]);
        end
        program_chan(2, 16'h200, 16'h203, ctrl_word(8'd63, 1'b0, 1'b0, 1'b1, 1'b1));
        sync_right_half();
        clear_capture();
        reg_write(2, REG_TRIGGER, 24'h0);
        wait_frames(9);
        check_words(1'b0, 1'b1);
        check_tail_zero();

        // Two channels summed with saturation
        w = '{16'h7000, 16'h7000, 16'h1000, 16'h9000, 16'h8000};
        v = '{16'h7000, 16'h0100, 16'h1000, 16'h9000, 16'h0001};
        exp_q = {};
        for (i = 0; i < 5; i++) begin
            mem_write(16'h300 + i, w[i]);
            mem_write(16'h310 + i, v[i]);
            s = int'($signed(w[i])) + int'($signed(v[i]));
            if (s > 32767) s = 32767;
            if (s < -32768) s = -32768;
            exp_q.push_back(s[15:0]);
        end
        program_chan(0, 16'h300, 16'h304, ctrl_word(8'd255, 1'b0, 1'b1, 1'b1, 1'b1));
        program_chan(3, 16'h310, 16'h314, ctrl_word(8'd255, 1'b0, 1'b1, 1'b1, 1'b1));
        sync_right_half();
        clear_capture();
        reg_write(0, REG_TRIGGER, 24'h0);
        reg_write(3, REG_TRIGGER, 24'h0);
        wait_frames(10);
        check_words(1'b0, 1'b1);
        check_words(1'b1, 1'b1);
        check_tail_zero();

        // Looping channel on both sides
        for (i = 0; i < 4; i++) begin
            w[i] = 16'($random(seed)) | 16'h0001;
            mem_write(16'h100 + i, w[i]);
        end
        exp_q = {};
        for (i = 0; i < 12; i++) exp_q.push_back(w[i % 4]);
        program_chan(1, 16'h100, 16'h103, ctrl_word(8'd255, 1'b1, 1'b1, 1'b1, 1'b1));
        sync_right_half();
        clear_capture();
        reg_write(1, REG_TRIGGER, 24'h0);
        wait_frames(15);
        check_words(1'b0, 1'b0);
        check_words(1'b1, 1'b0);

        // Disable mid-play and restart from the start address
        reg_write(1, REG_CTRL, ctrl_word(8'd255, 1'b1, 1'b1, 1'b1, 1'b0));
        wait_frames(2);
        clear_capture();
        wait_frames(4);
        exp_q = {};
        check_words(1'b0, 1'b1);
        check_words(1'b1, 1'b1);
        reg_write(1, REG_CTRL, ctrl_word(8'd255, 1'b1, 1'b1, 1'b1, 1'b1));
        sync_right_half();
        clear_capture();
        reg_write(1, REG_TRIGGER, 24'h0);
        wait_frames(4);
        exp_q = {w[0], w[1]};
        check_words(1'b0, 1'b0);
        check_words(1'b1, 1'b0);

        $display("Errors: data %0d, framing %0d", data_errors, frame_errors);
        if (data_errors == 0 && frame_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
